/* source/cfg_ctrl_defines.svh */
`ifndef CFG_CTRL_DEFINES_SVH
`define CFG_CTRL_DEFINES_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////
`define CFG_ADDR_W 32 // Requester side address
`define CFG_DATA_W 32
`define CFG_MADDR_W 15 // Target bus address after truncation
`define CFG_SEL_W 5

////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////
// Page numbers are the address bits above CFG_PAGE_LSB
`define CFG_PAGE_UP 20'h30000 // User project
`define CFG_PAGE_LA 20'h30001 // Logic analyzer
`define CFG_PAGE_CC 20'h30002 // Internal select register
`define CFG_PAGE_LSB 12

// Select register offset inside the CC page
`define CFG_SEL_OFFSET 12'h000

// Returned for reads that hit no target or no register
`define CFG_UNMAPPED_RDATA 32'hFFFF_FFFF

`endif

/* source/cfg_ctrl_pkg.sv */
`default_nettype none

`include "cfg_ctrl_defines.svh"

package cfg_ctrl_pkg;

	typedef logic [`CFG_ADDR_W-1:0] addr_t;
	typedef logic [`CFG_DATA_W-1:0] data_t;
	typedef logic [`CFG_MADDR_W-1:0] maddr_t; // Target bus address
	typedef logic [`CFG_SEL_W-1:0] sel_t;

	// Decoded page
	typedef enum logic [1:0] {
		TGT_UP,
		TGT_LA,
		TGT_CC,
		TGT_NONE
	} target_e;

	// Shared AXI-Lite master FSM
	typedef enum logic [2:0] {
		MST_IDLE,
		MST_RD_ADDR, // arvalid and rready up
		MST_RD_DATA, // Address taken, waiting on rvalid
		MST_WR_ADDR_DATA, // awvalid and wvalid up
		MST_WR_DATA // Address taken, waiting on wready
	} mst_state_e;

endpackage

`default_nettype wire

/* source/cfg_wb_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_wb_requester (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire wbs_cyc_i,
	input wire wbs_stb_i,
	input wire wbs_we_i,
	input wire cfg_ctrl_pkg::addr_t wbs_adr_i,
	input wire cfg_ctrl_pkg::data_t wbs_wdata_i,
	input wire ack_i,
	input wire cfg_ctrl_pkg::data_t rdata_i,
	output logic wbs_ack_o,
	output cfg_ctrl_pkg::data_t wbs_rdata_o,
	output logic req_o,
	output logic we_o,
	output cfg_ctrl_pkg::addr_t addr_o,
	output cfg_ctrl_pkg::data_t wdata_o
);

	logic accept;

	// New cycle only once the previous handshake has fully returned
	assign accept = wbs_cyc_i && wbs_stb_i && !req_o && !wbs_ack_o && !ack_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			req_o <= 1'b0;
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= 1'b0; // Single cycle ack
			if (accept) begin
				req_o <= 1'b1;
			end else if (req_o && ack_i) begin
				req_o <= 1'b0;
				wbs_ack_o <= 1'b1;
			end
		end
	end

	// Command and read data
	always_ff @(posedge axi_clk) begin
		if (accept) begin
			we_o <= wbs_we_i;
			addr_o <= wbs_adr_i;
			wdata_o <= wbs_wdata_i;
		end
		if (req_o && ack_i)
			wbs_rdata_o <= rdata_i; // Captured while ack is high
	end

endmodule

`default_nettype wire

/* source/cfg_axil_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_axil_requester (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire s_awvalid_i,
	input wire cfg_ctrl_pkg::addr_t s_awaddr_i,
	input wire s_wvalid_i,
	input wire cfg_ctrl_pkg::data_t s_wdata_i,
	input wire s_arvalid_i,
	input wire cfg_ctrl_pkg::addr_t s_araddr_i,
	input wire s_rready_i,
	input wire ack_i,
	input wire cfg_ctrl_pkg::data_t rdata_i,
	output logic s_awready_o,
	output logic s_wready_o,
	output logic s_arready_o,
	output logic s_rvalid_o,
	output cfg_ctrl_pkg::data_t s_rdata_o,
	output logic s_bvalid_o,
	output logic req_o,
	output logic we_o,
	output cfg_ctrl_pkg::addr_t addr_o,
	output cfg_ctrl_pkg::data_t wdata_o
);

	typedef enum logic [2:0] {
		AX_IDLE,
		AX_WDATA, // Address taken, waiting on write data
		AX_WREQ,
		AX_RREQ,
		AX_RRESP // rvalid held until rready
	} ax_state_e;

	ax_state_e state;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= AX_IDLE;
			s_awready_o <= 1'b0;
			s_wready_o <= 1'b0;
			s_arready_o <= 1'b0;
			s_rvalid_o <= 1'b0;
			s_bvalid_o <= 1'b0;
			req_o <= 1'b0;
		end else begin
			s_awready_o <= 1'b0;
			s_wready_o <= 1'b0;
			s_arready_o <= 1'b0;
			s_bvalid_o <= 1'b0;
			case (state)
				AX_IDLE: begin
					// Ack from the last request must be gone first
					if (s_awvalid_i && !ack_i) begin
						s_awready_o <= 1'b1;
						state <= AX_WDATA;
					end else if (s_arvalid_i && !ack_i) begin
						s_arready_o <= 1'b1;
						req_o <= 1'b1;
						state <= AX_RREQ;
					end
				end
				AX_WDATA: begin
					if (s_wvalid_i) begin
						s_wready_o <= 1'b1;
						req_o <= 1'b1;
						state <= AX_WREQ;
					end
				end
				AX_WREQ: begin
					if (ack_i) begin
						req_o <= 1'b0;
						s_bvalid_o <= 1'b1;
						state <= AX_IDLE;
					end
				end
				AX_RREQ: begin
					if (ack_i) begin
						req_o <= 1'b0;
						s_rvalid_o <= 1'b1;
						state <= AX_RRESP;
					end
				end
				AX_RRESP: begin
					if (s_rready_i) begin
						s_rvalid_o <= 1'b0;
						state <= AX_IDLE;
					end
				end
				default: state <= AX_IDLE;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (state == AX_IDLE) begin
			we_o <= s_awvalid_i; // Write wins over read
			addr_o <= s_awvalid_i ? s_awaddr_i : s_araddr_i;
		end
		if (state == AX_WDATA && s_wvalid_i)
			wdata_o <= s_wdata_i;
		if (state == AX_RREQ && ack_i)
			s_rdata_o <= rdata_i;
	end

endmodule

`default_nettype wire

/* source/cfg_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_arbiter (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire wb_req_i,
	input wire wb_we_i,
	input wire cfg_ctrl_pkg::addr_t wb_addr_i,
	input wire cfg_ctrl_pkg::data_t wb_wdata_i,
	input wire ax_req_i,
	input wire ax_we_i,
	input wire cfg_ctrl_pkg::addr_t ax_addr_i,
	input wire cfg_ctrl_pkg::data_t ax_wdata_i,
	input wire done_i,
	input wire cfg_ctrl_pkg::data_t rdata_i,
	output logic wb_ack_o,
	output cfg_ctrl_pkg::data_t wb_rdata_o,
	output logic ax_ack_o,
	output cfg_ctrl_pkg::data_t ax_rdata_o,
	output logic start_o,
	output logic we_o,
	output cfg_ctrl_pkg::addr_t addr_o,
	output cfg_ctrl_pkg::data_t wdata_o,
	output logic active_o
);

	logic grant; // 0 Wishbone, 1 AXI-Lite
	logic owner_req;
	logic pending; // Master busy for the owner
	logic ack_q;
	cfg_ctrl_pkg::data_t rdata_q;

	assign owner_req = grant ? ax_req_i : wb_req_i;
	assign we_o = grant ? ax_we_i : wb_we_i;
	assign addr_o = grant ? ax_addr_i : wb_addr_i;
	assign wdata_o = grant ? ax_wdata_i : wb_wdata_i;
	assign active_o = owner_req;

	// One pulse per request, never while the old ack is still up
	assign start_o = owner_req && !pending && !ack_q;

	assign wb_ack_o = ack_q && !grant;
	assign ax_ack_o = ack_q && grant;
	assign wb_rdata_o = rdata_q;
	assign ax_rdata_o = rdata_q;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			grant <= 1'b0; // Parked on Wishbone
			pending <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			if (start_o)
				pending <= 1'b1;
			else if (done_i)
				pending <= 1'b0;

			if (done_i)
				ack_q <= 1'b1;
			else if (ack_q && !owner_req)
				ack_q <= 1'b0;

			// Once the owner's handshake has closed, hand over or park on Wishbone
			if (!owner_req && !pending && !ack_q)
				grant <= ax_req_i && !wb_req_i;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (done_i)
			rdata_q <= rdata_i;
	end

endmodule

`default_nettype wire

/* source/cfg_target_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ctrl_defines.svh"

module cfg_target_decode (
	input wire active_i,
	input wire cfg_ctrl_pkg::addr_t addr_i,
	input wire awvalid_i,
	input wire wvalid_i,
	input wire arvalid_i,
	input wire up_awready_i,
	input wire up_wready_i,
	input wire up_arready_i,
	input wire up_rvalid_i,
	input wire cfg_ctrl_pkg::data_t up_rdata_i,
	input wire la_awready_i,
	input wire la_wready_i,
	input wire la_arready_i,
	input wire la_rvalid_i,
	input wire cfg_ctrl_pkg::data_t la_rdata_i,
	input wire cc_awready_i,
	input wire cc_wready_i,
	input wire cc_arready_i,
	input wire cc_rvalid_i,
	input wire cfg_ctrl_pkg::data_t cc_rdata_i,
	output logic up_en_o,
	output logic la_en_o,
	output logic cc_en_o,
	output logic awready_o,
	output logic wready_o,
	output logic arready_o,
	output logic rvalid_o,
	output cfg_ctrl_pkg::data_t rdata_o
);

	logic [`CFG_ADDR_W-`CFG_PAGE_LSB-1:0] page;
	cfg_ctrl_pkg::target_e tgt;
	logic none_en;

	assign page = addr_i[`CFG_ADDR_W-1:`CFG_PAGE_LSB];

	always_comb begin
		case (page)
			`CFG_PAGE_UP: tgt = cfg_ctrl_pkg::TGT_UP;
			`CFG_PAGE_LA: tgt = cfg_ctrl_pkg::TGT_LA;
			`CFG_PAGE_CC: tgt = cfg_ctrl_pkg::TGT_CC;
			default: tgt = cfg_ctrl_pkg::TGT_NONE;
		endcase
	end

	// One hot, all low between requests
	assign up_en_o = active_i && (tgt == cfg_ctrl_pkg::TGT_UP);
	assign la_en_o = active_i && (tgt == cfg_ctrl_pkg::TGT_LA);
	assign cc_en_o = active_i && (tgt == cfg_ctrl_pkg::TGT_CC);
	assign none_en = active_i && (tgt == cfg_ctrl_pkg::TGT_NONE);

	// Unmapped page answers in the same cycle from the master's valids
	assign awready_o = (up_en_o & up_awready_i) | (la_en_o & la_awready_i) |
		(cc_en_o & cc_awready_i) | (none_en & awvalid_i);
	assign wready_o = (up_en_o & up_wready_i) | (la_en_o & la_wready_i) |
		(cc_en_o & cc_wready_i) | (none_en & wvalid_i);
	assign arready_o = (up_en_o & up_arready_i) | (la_en_o & la_arready_i) |
		(cc_en_o & cc_arready_i) | (none_en & arvalid_i);
	assign rvalid_o = (up_en_o & up_rvalid_i) | (la_en_o & la_rvalid_i) |
		(cc_en_o & cc_rvalid_i) | (none_en & arvalid_i);

	always_comb begin
		case (tgt)
			cfg_ctrl_pkg::TGT_UP: rdata_o = up_rdata_i;
			cfg_ctrl_pkg::TGT_LA: rdata_o = la_rdata_i;
			cfg_ctrl_pkg::TGT_CC: rdata_o = cc_rdata_i;
			default: rdata_o = `CFG_UNMAPPED_RDATA;
		endcase
	end

endmodule

`default_nettype wire

/* source/cfg_axil_master.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ctrl_defines.svh"

module cfg_axil_master (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire start_i,
	input wire we_i,
	input wire cfg_ctrl_pkg::addr_t addr_i,
	input wire cfg_ctrl_pkg::data_t wdata_i,
	input wire awready_i,
	input wire wready_i,
	input wire arready_i,
	input wire rvalid_i,
	input wire cfg_ctrl_pkg::data_t rdata_i,
	output logic awvalid_o,
	output cfg_ctrl_pkg::maddr_t awaddr_o,
	output logic wvalid_o,
	output cfg_ctrl_pkg::data_t wdata_o,
	output logic arvalid_o,
	output cfg_ctrl_pkg::maddr_t araddr_o,
	output logic rready_o,
	output logic done_o,
	output cfg_ctrl_pkg::data_t rdata_o
);

	cfg_ctrl_pkg::mst_state_e state;
	logic aw_ok; // Address phase finished or finishing now
	logic w_ok;

	assign aw_ok = !awvalid_o || awready_i;
	assign w_ok = !wvalid_o || wready_i;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state <= cfg_ctrl_pkg::MST_IDLE;
			awvalid_o <= 1'b0;
			wvalid_o <= 1'b0;
			arvalid_o <= 1'b0;
			rready_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				cfg_ctrl_pkg::MST_IDLE: begin
					if (start_i && we_i) begin
						awvalid_o <= 1'b1;
						wvalid_o <= 1'b1;
						state <= cfg_ctrl_pkg::MST_WR_ADDR_DATA;
					end else if (start_i) begin
						arvalid_o <= 1'b1;
						rready_o <= 1'b1;
						state <= cfg_ctrl_pkg::MST_RD_ADDR;
					end
				end
				cfg_ctrl_pkg::MST_RD_ADDR: begin
					if (arready_i) begin
						arvalid_o <= 1'b0;
						if (rvalid_i) begin // Both handshakes in one cycle
							rready_o <= 1'b0;
							done_o <= 1'b1;
							state <= cfg_ctrl_pkg::MST_IDLE;
						end else
							state <= cfg_ctrl_pkg::MST_RD_DATA;
					end
				end
				cfg_ctrl_pkg::MST_RD_DATA: begin
					if (rvalid_i) begin
						rready_o <= 1'b0;
						done_o <= 1'b1;
						state <= cfg_ctrl_pkg::MST_IDLE;
					end
				end
				cfg_ctrl_pkg::MST_WR_ADDR_DATA: begin
					// Either ready may come first
					if (awvalid_o && awready_i)
						awvalid_o <= 1'b0;
					if (wvalid_o && wready_i)
						wvalid_o <= 1'b0;
					if (aw_ok && w_ok) begin
						done_o <= 1'b1;
						state <= cfg_ctrl_pkg::MST_IDLE;
					end else if (aw_ok)
						state <= cfg_ctrl_pkg::MST_WR_DATA;
				end
				cfg_ctrl_pkg::MST_WR_DATA: begin
					if (wready_i) begin
						wvalid_o <= 1'b0;
						done_o <= 1'b1;
						state <= cfg_ctrl_pkg::MST_IDLE;
					end
				end
				default: state <= cfg_ctrl_pkg::MST_IDLE;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (start_i && state == cfg_ctrl_pkg::MST_IDLE) begin
			awaddr_o <= addr_i[`CFG_MADDR_W-1:0]; // Page bits above 14 dropped
			araddr_o <= addr_i[`CFG_MADDR_W-1:0];
			wdata_o <= wdata_i;
		end
		if (rready_o && rvalid_i)
			rdata_o <= rdata_i;
	end

endmodule

`default_nettype wire

/* source/cfg_sel_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ctrl_defines.svh"

module cfg_sel_regs (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire en_i,
	input wire awvalid_i,
	input wire cfg_ctrl_pkg::maddr_t awaddr_i,
	input wire wvalid_i,
	input wire cfg_ctrl_pkg::data_t wdata_i,
	input wire arvalid_i,
	input wire cfg_ctrl_pkg::maddr_t araddr_i,
	input wire rready_i,
	output logic awready_o,
	output logic wready_o,
	output logic arready_o,
	output logic rvalid_o,
	output cfg_ctrl_pkg::data_t rdata_o,
	output cfg_ctrl_pkg::sel_t user_prj_sel_o
);

	logic wr_hit;
	logic rd_hit;

	// Master holds awaddr through the whole write
	assign wr_hit = awaddr_i[`CFG_PAGE_LSB-1:0] == `CFG_SEL_OFFSET;
	assign rd_hit = araddr_i[`CFG_PAGE_LSB-1:0] == `CFG_SEL_OFFSET;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			rvalid_o <= 1'b0;
			user_prj_sel_o <= '0;
		end else begin
			// Readies are one cycle pulses, a cycle after valid
			awready_o <= en_i && awvalid_i && !awready_o;
			wready_o <= en_i && wvalid_i && !wready_o;
			arready_o <= en_i && arvalid_i && !arready_o && !rvalid_o;

			if (wvalid_i && wready_o && wr_hit)
				user_prj_sel_o <= wdata_i[`CFG_SEL_W-1:0];

			if (arvalid_i && arready_o)
				rvalid_o <= 1'b1;
			else if (rvalid_o && rready_i)
				rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge axi_clk) begin
		if (arvalid_i && arready_o) begin
			if (rd_hit)
				rdata_o <= {{(`CFG_DATA_W-`CFG_SEL_W){1'b0}}, user_prj_sel_o};
			else
				rdata_o <= `CFG_UNMAPPED_RDATA; // No other registers here
		end
	end

endmodule

`default_nettype wire

/* source/cfg_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_top (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire wbs_cyc_i,
	input wire wbs_stb_i,
	input wire wbs_we_i,
	input wire cfg_ctrl_pkg::addr_t wbs_adr_i,
	input wire cfg_ctrl_pkg::data_t wbs_wdata_i,
	output logic wbs_ack_o,
	output cfg_ctrl_pkg::data_t wbs_rdata_o,
	input wire s_awvalid_i,
	input wire cfg_ctrl_pkg::addr_t s_awaddr_i,
	input wire s_wvalid_i,
	input wire cfg_ctrl_pkg::data_t s_wdata_i,
	input wire s_arvalid_i,
	input wire cfg_ctrl_pkg::addr_t s_araddr_i,
	input wire s_rready_i,
	output logic s_awready_o,
	output logic s_wready_o,
	output logic s_arready_o,
	output logic s_rvalid_o,
	output cfg_ctrl_pkg::data_t s_rdata_o,
	output logic s_bvalid_o,
	output logic axi_awvalid_o,
	output cfg_ctrl_pkg::maddr_t axi_awaddr_o,
	output logic axi_wvalid_o,
	output cfg_ctrl_pkg::data_t axi_wdata_o,
	output logic axi_arvalid_o,
	output cfg_ctrl_pkg::maddr_t axi_araddr_o,
	output logic axi_rready_o,
	input wire up_awready_i,
	input wire up_wready_i,
	input wire up_arready_i,
	input wire up_rvalid_i,
	input wire cfg_ctrl_pkg::data_t up_rdata_i,
	input wire la_awready_i,
	input wire la_wready_i,
	input wire la_arready_i,
	input wire la_rvalid_i,
	input wire cfg_ctrl_pkg::data_t la_rdata_i,
	output logic up_en_o,
	output logic la_en_o,
	output cfg_ctrl_pkg::sel_t user_prj_sel_o
);

	////////////////////////////////////////////////////////////
	// Requester to arbiter
	////////////////////////////////////////////////////////////
	logic wb_req, wb_we, wb_ack;
	logic ax_req, ax_we, ax_ack;
	cfg_ctrl_pkg::addr_t wb_addr, ax_addr;
	cfg_ctrl_pkg::data_t wb_wdata, wb_rdata, ax_wdata, ax_rdata;

	////////////////////////////////////////////////////////////
	// Arbiter, master and targets
	////////////////////////////////////////////////////////////
	logic start, m_we, active, done;
	cfg_ctrl_pkg::addr_t m_addr;
	cfg_ctrl_pkg::data_t m_wdata, m_rdata;
	logic awready, wready, arready, rvalid; // Steered back from the selected target
	cfg_ctrl_pkg::data_t rdata;
	logic cc_en, cc_awready, cc_wready, cc_arready, cc_rvalid;
	cfg_ctrl_pkg::data_t cc_rdata;

	cfg_wb_requester u_wb_req (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
		.wbs_adr_i(wbs_adr_i), .wbs_wdata_i(wbs_wdata_i),
		.ack_i(wb_ack), .rdata_i(wb_rdata),
		.wbs_ack_o(wbs_ack_o), .wbs_rdata_o(wbs_rdata_o),
		.req_o(wb_req), .we_o(wb_we), .addr_o(wb_addr), .wdata_o(wb_wdata)
	);

	cfg_axil_requester u_ax_req (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.s_awvalid_i(s_awvalid_i), .s_awaddr_i(s_awaddr_i),
		.s_wvalid_i(s_wvalid_i), .s_wdata_i(s_wdata_i),
		.s_arvalid_i(s_arvalid_i), .s_araddr_i(s_araddr_i), .s_rready_i(s_rready_i),
		.ack_i(ax_ack), .rdata_i(ax_rdata),
		.s_awready_o(s_awready_o), .s_wready_o(s_wready_o), .s_arready_o(s_arready_o),
		.s_rvalid_o(s_rvalid_o), .s_rdata_o(s_rdata_o), .s_bvalid_o(s_bvalid_o),
		.req_o(ax_req), .we_o(ax_we), .addr_o(ax_addr), .wdata_o(ax_wdata)
	);

	cfg_arbiter u_arb (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.wb_req_i(wb_req), .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_wdata_i(wb_wdata),
		.ax_req_i(ax_req), .ax_we_i(ax_we), .ax_addr_i(ax_addr), .ax_wdata_i(ax_wdata),
		.done_i(done), .rdata_i(m_rdata),
		.wb_ack_o(wb_ack), .wb_rdata_o(wb_rdata), .ax_ack_o(ax_ack), .ax_rdata_o(ax_rdata),
		.start_o(start), .we_o(m_we), .addr_o(m_addr), .wdata_o(m_wdata),
		.active_o(active)
	);

	cfg_axil_master u_mst (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n),
		.start_i(start), .we_i(m_we), .addr_i(m_addr), .wdata_i(m_wdata),
		.awready_i(awready), .wready_i(wready), .arready_i(arready),
		.rvalid_i(rvalid), .rdata_i(rdata),
		.awvalid_o(axi_awvalid_o), .awaddr_o(axi_awaddr_o),
		.wvalid_o(axi_wvalid_o), .wdata_o(axi_wdata_o),
		.arvalid_o(axi_arvalid_o), .araddr_o(axi_araddr_o), .rready_o(axi_rready_o),
		.done_o(done), .rdata_o(m_rdata)
	);

	cfg_target_decode u_dec (
		.active_i(active), .addr_i(m_addr),
		.awvalid_i(axi_awvalid_o), .wvalid_i(axi_wvalid_o), .arvalid_i(axi_arvalid_o),
		.up_awready_i(up_awready_i), .up_wready_i(up_wready_i),
		.up_arready_i(up_arready_i), .up_rvalid_i(up_rvalid_i), .up_rdata_i(up_rdata_i),
		.la_awready_i(la_awready_i), .la_wready_i(la_wready_i),
		.la_arready_i(la_arready_i), .la_rvalid_i(la_rvalid_i), .la_rdata_i(la_rdata_i),
		.cc_awready_i(cc_awready), .cc_wready_i(cc_wready),
		.cc_arready_i(cc_arready), .cc_rvalid_i(cc_rvalid), .cc_rdata_i(cc_rdata),
		.up_en_o(up_en_o), .la_en_o(la_en_o), .cc_en_o(cc_en),
		.awready_o(awready), .wready_o(wready), .arready_o(arready),
		.rvalid_o(rvalid), .rdata_o(rdata)
	);

	cfg_sel_regs u_sel (
		.axi_clk(axi_clk), .axi_reset_n(axi_reset_n), .en_i(cc_en),
		.awvalid_i(axi_awvalid_o), .awaddr_i(axi_awaddr_o),
		.wvalid_i(axi_wvalid_o), .wdata_i(axi_wdata_o),
		.arvalid_i(axi_arvalid_o), .araddr_i(axi_araddr_o), .rready_i(axi_rready_o),
		.awready_o(cc_awready), .wready_o(cc_wready), .arready_o(cc_arready),
		.rvalid_o(cc_rvalid), .rdata_o(cc_rdata), .user_prj_sel_o(user_prj_sel_o)
	);

endmodule

`default_nettype wire

/* testbench/cfg_ctrl_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl_assert (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire cfg_ctrl_pkg::mst_state_e state,
	input wire start,
	input wire awvalid,
	input wire awready,
	input wire wb_req,
	input wire wb_ack,
	input wire ax_req,
	input wire ax_ack,
	input wire [2:0] en
);

	// Address valid stays up until the target takes it
	a_aw_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	// Arbiter only starts the master between accesses
	a_start_idle: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		start |-> state == cfg_ctrl_pkg::MST_IDLE)
		else $error("start pulsed while the master was busy");

	a_en_onehot: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$onehot0(en))
		else $error("more than one target enable high");

	a_wb_ack: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$rose(wb_ack) |-> $past(wb_req))
		else $error("Wishbone ack rose without a request");

	a_ax_ack: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$rose(ax_ack) |-> $past(ax_req))
		else $error("AXI-Lite ack rose without a request");

endmodule

bind cfg_ctrl_top cfg_ctrl_assert u_cfg_ctrl_assert (
	.axi_clk(axi_clk), .axi_reset_n(axi_reset_n), .state(u_mst.state),
	.start(start), .awvalid(axi_awvalid_o), .awready(awready),
	.wb_req(wb_req), .wb_ack(wb_ack), .ax_req(ax_req), .ax_ack(ax_ack),
	.en({up_en_o, la_en_o, cc_en})
);

`default_nettype wire

/* testbench/tb_cfg_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cfg_ctrl_defines.svh"

// External target with random ready delays and a 16 word memory
module target_model (
	input wire axi_clk,
	input wire axi_reset_n,
	input wire en_i,
	input wire awvalid_i,
	input wire cfg_ctrl_pkg::maddr_t awaddr_i,
	input wire wvalid_i,
	input wire cfg_ctrl_pkg::data_t wdata_i,
	input wire arvalid_i,
	input wire cfg_ctrl_pkg::maddr_t araddr_i,
	input wire rready_i,
	output logic awready_o,
	output logic wready_o,
	output logic arready_o,
	output logic rvalid_o,
	output cfg_ctrl_pkg::data_t rdata_o
);

	cfg_ctrl_pkg::data_t mem [0:15];
	logic [2:0] phase; // 0 idle, 1 armed, 2 read data, 3 gap
	logic [1:0] wait_cnt;

	initial begin
		for (int i = 0; i < 16; i++)
			mem[i] = '0;
	end

	always @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			phase <= 3'd0;
			wait_cnt <= 2'd0;
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			rvalid_o <= 1'b0;
			rdata_o <= '0;
		end else begin
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			rvalid_o <= 1'b0;
			if (wait_cnt != 2'd0)
				wait_cnt <= wait_cnt - 2'd1;
			else case (phase)
				3'd0: if (en_i && (awvalid_i || arvalid_i)) begin
					wait_cnt <= 2'($urandom % 4);
					phase <= 3'd1;
				end
				3'd1: if (awvalid_i) begin
					awready_o <= 1'b1;
					wready_o <= 1'b1;
					mem[awaddr_i[5:2]] <= wdata_i;
					phase <= 3'd3;
				end else begin
					arready_o <= 1'b1;
					wait_cnt <= 2'($urandom % 4);
					phase <= 3'd2;
				end
				3'd2: begin
					rvalid_o <= 1'b1;
					rdata_o <= mem[araddr_i[5:2]];
					if (rvalid_o && rready_i) begin // Held until the master takes it
						rvalid_o <= 1'b0;
						phase <= 3'd3;
					end
				end
				default: phase <= 3'd0; // Lets the master drop its valids
			endcase
		end
	end

endmodule

module tb_cfg_ctrl;

	logic axi_clk = 1'b0;
	logic axi_reset_n = 1'b0;
	logic wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
	cfg_ctrl_pkg::addr_t wbs_adr_i, s_awaddr_i, s_araddr_i;
	cfg_ctrl_pkg::data_t wbs_wdata_i, wbs_rdata_o, s_wdata_i, s_rdata_o;
	logic s_awvalid_i, s_wvalid_i, s_arvalid_i, s_rready_i;
	logic s_awready_o, s_wready_o, s_arready_o, s_rvalid_o, s_bvalid_o;
	logic axi_awvalid_o, axi_wvalid_o, axi_arvalid_o, axi_rready_o;
	cfg_ctrl_pkg::maddr_t axi_awaddr_o, axi_araddr_o;
	cfg_ctrl_pkg::data_t axi_wdata_o, up_rdata, la_rdata;
	logic up_awready, up_wready, up_arready, up_rvalid;
	logic la_awready, la_wready, la_arready, la_rvalid;
	logic up_en_o, la_en_o;
	cfg_ctrl_pkg::sel_t user_prj_sel_o;

	logic [31:0] pat [0:159];
	int cycles = 0;
	int limit = 0;
	int up_cnt = 0;
	int la_cnt = 0;
	int data_errs = 0;
	int sel_errs = 0;
	int flag_errs = 0;
	int other_errs = 0;

	always #5 axi_clk = !axi_clk;

	cfg_ctrl_top u_cfg_ctrl_top (.*,
		.up_awready_i(up_awready), .up_wready_i(up_wready), .up_arready_i(up_arready),
		.up_rvalid_i(up_rvalid), .up_rdata_i(up_rdata),
		.la_awready_i(la_awready), .la_wready_i(la_wready), .la_arready_i(la_arready),
		.la_rvalid_i(la_rvalid), .la_rdata_i(la_rdata));

	target_model u_up (.axi_clk, .axi_reset_n, .en_i(up_en_o),
		.awvalid_i(axi_awvalid_o), .awaddr_i(axi_awaddr_o), .wvalid_i(axi_wvalid_o),
		.wdata_i(axi_wdata_o), .arvalid_i(axi_arvalid_o), .araddr_i(axi_araddr_o),
		.rready_i(axi_rready_o),
		.awready_o(up_awready), .wready_o(up_wready), .arready_o(up_arready),
		.rvalid_o(up_rvalid), .rdata_o(up_rdata));

	target_model u_la (.axi_clk, .axi_reset_n, .en_i(la_en_o),
		.awvalid_i(axi_awvalid_o), .awaddr_i(axi_awaddr_o), .wvalid_i(axi_wvalid_o),
		.wdata_i(axi_wdata_o), .arvalid_i(axi_arvalid_o), .araddr_i(axi_araddr_o),
		.rready_i(axi_rready_o),
		.awready_o(la_awready), .wready_o(la_wready), .arready_o(la_arready),
		.rvalid_o(la_rvalid), .rdata_o(la_rdata));

	// Cycle counter, enable activity and the run limit
	always @(posedge axi_clk) begin
		cycles <= cycles + 1;
		up_cnt <= up_cnt + int'(up_en_o);
		la_cnt <= la_cnt + int'(la_en_o);
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, an access never completed", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_data(input string name, input cfg_ctrl_pkg::data_t got,
		input cfg_ctrl_pkg::data_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_sel(input string name, input cfg_ctrl_pkg::sel_t got,
		input cfg_ctrl_pkg::sel_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			sel_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			flag_errs++;
		end
	endtask

	task automatic wb_access(input logic we, input cfg_ctrl_pkg::addr_t addr,
		input cfg_ctrl_pkg::data_t wdata, output cfg_ctrl_pkg::data_t rdata);
		@(posedge axi_clk);
		wbs_cyc_i <= 1'b1;
		wbs_stb_i <= 1'b1;
		wbs_we_i <= we;
		wbs_adr_i <= addr;
		wbs_wdata_i <= wdata;
		do @(posedge axi_clk); while (!wbs_ack_o);
		rdata = wbs_rdata_o;
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
	endtask

	task automatic ax_write(input cfg_ctrl_pkg::addr_t addr, input cfg_ctrl_pkg::data_t wdata);
		@(posedge axi_clk);
		s_awvalid_i <= 1'b1;
		s_awaddr_i <= addr;
		s_wvalid_i <= 1'b1;
		s_wdata_i <= wdata;
		do begin
			@(posedge axi_clk);
			if (s_awready_o)
				s_awvalid_i <= 1'b0;
			if (s_wready_o)
				s_wvalid_i <= 1'b0;
		end while (!s_bvalid_o);
	endtask

	task automatic ax_read(input cfg_ctrl_pkg::addr_t addr, output cfg_ctrl_pkg::data_t rdata);
		@(posedge axi_clk);
		s_arvalid_i <= 1'b1;
		s_araddr_i <= addr;
		do begin
			@(posedge axi_clk);
			if (s_arready_o)
				s_arvalid_i <= 1'b0;
		end while (!s_rvalid_o);
		rdata = s_rdata_o;
		s_rready_i <= 1'b1; // Read data held until now
		@(posedge axi_clk);
		s_rready_i <= 1'b0;
	endtask

	task automatic run_access(input int idx, output cfg_ctrl_pkg::data_t rdata);
		if (pat[idx] == 32'd0)
			wb_access(pat[idx+1][0], pat[idx+2], pat[idx+3], rdata);
		else if (pat[idx+1][0])
			ax_write(pat[idx+2], pat[idx+3]);
		else
			ax_read(pat[idx+2], rdata);
	endtask

	task automatic check_result(input int idx, input cfg_ctrl_pkg::data_t rdata);
		if (pat[idx+1][0])
			check_sel("user_prj_sel_o", user_prj_sel_o, pat[idx+4][`CFG_SEL_W-1:0]);
		else
			check_data(pat[idx] == 32'd0 ? "wbs_rdata_o" : "s_rdata_o", rdata, pat[idx+4]);
	endtask

	initial begin
		int i;
		int npat;
		int up0, la0, wb_end, ax_end;
		logic [19:0] page;
		cfg_ctrl_pkg::data_t rd_a, rd_b;
		void'($urandom(2));
		{wbs_cyc_i, wbs_stb_i, wbs_we_i, s_awvalid_i, s_wvalid_i, s_arvalid_i} = '0;
		s_rready_i = 1'b0;
		{wbs_adr_i, wbs_wdata_i, s_awaddr_i, s_wdata_i, s_araddr_i} = '0;
		$readmemh("testbench/cfg_ctrl_patterns.txt", pat);
		npat = 0;
		while (pat[npat*5] != 32'hf)
			npat++;
		if (npat == 0) begin
			$display("Pattern file missing or empty, no accesses to run");
			other_errs++;
		end
		limit = npat * 40 + 20;
		repeat (4) @(posedge axi_clk);
		axi_reset_n <= 1'b1;
		@(posedge axi_clk);
		check_sel("user_prj_sel_o", user_prj_sel_o, '0);
		i = 0;
		while (pat[i*5] != 32'hf) begin
			if (pat[i*5] == 32'd2) begin
				// Both ports start in the same cycle
				fork
					begin
						wb_access(pat[i*5+1][0], pat[i*5+2], pat[i*5+3], rd_a);
						wb_end = cycles;
					end
					begin
						run_access((i+1)*5, rd_b);
						ax_end = cycles;
					end
				join
				check_data("wbs_rdata_o", rd_a, pat[i*5+4]);
				check_result((i+1)*5, rd_b);
				if (wb_end >= ax_end) begin
					$display("Overlap order wrong, Wishbone finished at %0d and AXI-Lite at %0d",
						wb_end, ax_end);
					other_errs++;
				end
				i += 2;
			end else begin
				up0 = up_cnt;
				la0 = la_cnt;
				run_access(i*5, rd_a);
				@(posedge axi_clk);
				check_result(i*5, rd_a);
				page = pat[i*5+2][31:`CFG_PAGE_LSB];
				check_flag("up_en_o", up_cnt != up0, page == `CFG_PAGE_UP);
				check_flag("la_en_o", la_cnt != la0, page == `CFG_PAGE_LA);
				i++;
			end
		end
		repeat (4) @(posedge axi_clk);
		$display("Errors: data %0d, select %0d, enable %0d, other %0d",
			data_errs, sel_errs, flag_errs, other_errs);
		if (data_errs + sel_errs + flag_errs + other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/cfg_ctrl_patterns.txt */
// port (0 wishbone, 1 axi-lite, 2 wishbone started with the next line) dir (0 read, 1 write)
// address, write data, expected value (read data, or user_prj_sel after a write)
0 1 30000008 a5a50001 00000000
0 0 30000008 00000000 a5a50001
1 1 30001010 5a5a0002 00000000
1 0 30001010 00000000 5a5a0002
0 1 30002000 0000003b 0000001b
0 0 30002000 00000000 0000001b
1 0 30002004 00000000 ffffffff
1 1 30002000 00000006 00000006
1 0 30002000 00000000 00000006
0 0 30010000 00000000 ffffffff
1 0 20000000 00000000 ffffffff
0 1 30010008 deadbeef 00000006
1 1 20000010 deadbeef 00000006
0 0 30000008 00000000 a5a50001
1 0 30001010 00000000 5a5a0002
2 0 30001010 00000000 5a5a0002
1 0 30000008 00000000 a5a50001
f 0 00000000 00000000 00000000

/* sim.f */
+incdir+source
source/cfg_ctrl_pkg.sv
source/cfg_wb_requester.sv
source/cfg_axil_requester.sv
source/cfg_arbiter.sv
source/cfg_target_decode.sv
source/cfg_axil_master.sv
source/cfg_sel_regs.sv
source/cfg_ctrl_top.sv
testbench/cfg_ctrl_assert.sv
testbench/tb_cfg_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_cfg_ctrl -o tb_cfg_ctrl \
	&& ./obj_dir/tb_cfg_ctrl | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
